// File: source/video_timing_pkg.sv
//==========================================================================
// fixed 640x480 raster with a 25 MHz pixel clock, no other mode exists
// horizontal constants are in pixel clocks, vertical ones in lines
// blanking sits before the active pixels on each line
//==========================================================================

package video_timing_pkg;

    // raster coordinates as seen by the rest of the design
    typedef logic [11:0] raster_x_t;
    typedef logic [10:0] raster_y_t;

    // horizontal geometry
    localparam raster_x_t h_active = 12'd640;
    localparam raster_x_t h_front = 12'd16;
    localparam raster_x_t h_sync = 12'd96;
    localparam raster_x_t h_back = 12'd48;
    localparam raster_x_t h_total = h_active + h_front + h_sync + h_back;

    // sync, front and back porch all come ahead of the visible area
    localparam raster_x_t h_offscreen = h_sync + h_front + h_back;

    // vertical geometry
    localparam raster_y_t v_active = 11'd480;
    localparam raster_y_t v_front = 11'd11;
    localparam raster_y_t v_sync = 11'd2;
    localparam raster_y_t v_back = 11'd31;
    localparam raster_y_t v_total = v_active + v_front + v_sync + v_back;

endpackage

// File: source/vdp_regs_pkg.sv
//==========================================================================
// host register map and the structs used on the VRAM write path
// VRAM is two 16-bit banks, even and odd, addressed by word
// the queue depth is also the number of credits the host starts with
//==========================================================================

package vdp_regs_pkg;

    typedef logic [5:0] reg_addr_t;

    // readback registers
    localparam reg_addr_t reg_read_x = 6'd0;
    localparam reg_addr_t reg_read_y = 6'd2;

    // write registers
    localparam reg_addr_t reg_vram_addr = 6'd4;
    localparam reg_addr_t reg_vram_data = 6'd5;
    localparam reg_addr_t reg_vram_inc = 6'd6;

    typedef logic [13:0] vram_word_addr_t;

    typedef struct packed {
        reg_addr_t address;
        logic [15:0] write_data;
        logic write_en;
        logic read_en;
    } host_req_t;

    // one host write waiting for its bus slot
    typedef struct packed {
        vram_word_addr_t word_addr;
        logic [15:0] data;
        logic odd_bank;
    } vram_write_t;

    typedef struct packed {
        vram_word_addr_t address;
        logic write_en;
        logic [15:0] write_data;
    } vram_port_t;

    localparam int vram_queue_depth = 2;

endpackage

// File: source/raster_timing.sv
//==========================================================================
// raster counters for the fixed 640x480 mode
// x runs 0..799 and y runs 0..523, both restart at reset
// sync polarity is negative, all decoded outputs are combinational
//==========================================================================

`timescale 1ns/1ps

module raster_timing (
    input  logic clk,
    input  logic reset,

    output video_timing_pkg::raster_x_t raster_x,
    output video_timing_pkg::raster_y_t raster_y,

    output logic hsync,
    output logic vsync,
    output logic active_display,

    // single-cycle strobes
    output logic line_ended,
    output logic frame_ended
);

    logic last_line;

    assign line_ended = raster_x == video_timing_pkg::h_total - 1'b1;
    assign last_line = raster_y == video_timing_pkg::v_total - 1'b1;
    assign frame_ended = line_ended && last_line;

    always_ff @(posedge clk) begin
        if (reset) begin
            raster_x <= '0;
            raster_y <= '0;
        end else if (line_ended) begin
            raster_x <= '0;
            raster_y <= last_line ? '0 : raster_y + 1'b1;
        end else begin
            raster_x <= raster_x + 1'b1;
        end
    end

    // hsync pulse opens every line
    assign hsync = raster_x >= video_timing_pkg::h_sync;

    // vsync follows the vertical front porch
    assign vsync = !(raster_y >= video_timing_pkg::v_active + video_timing_pkg::v_front &&
        raster_y < video_timing_pkg::v_active + video_timing_pkg::v_front +
        video_timing_pkg::v_sync);

    assign active_display = raster_x >= video_timing_pkg::h_offscreen &&
        raster_y < video_timing_pkg::v_active;

endmodule

// File: source/vram_slot_sequencer.sv
//==========================================================================
// eight-cycle VRAM bus slot sequence, host slot is the last state
// stays aligned with raster_x modulo 8 since both restart at reset
// during vertical blanking every cycle is a host slot
//==========================================================================

`timescale 1ns/1ps

module vram_slot_sequencer (
    input  logic clk,
    input  logic reset,

    input  video_timing_pkg::raster_y_t raster_y,
    input  logic queue_valid,

    output logic slot_grant
);

    logic [2:0] slot;
    logic host_slot;
    logic vblank;

    // one state per clock, wraps every eight
    always_ff @(posedge clk) begin
        if (reset) begin
            slot <= '0;
        end else begin
            slot <= slot + 1'b1;
        end
    end

    // the other seven slots belonged to render fetches and are idle here
    assign host_slot = slot == 3'd7;

    assign vblank = raster_y >= video_timing_pkg::v_active;

    assign slot_grant = queue_valid && (host_slot || vblank);

endmodule

// File: source/host_registers.sv
//==========================================================================
// host register file for VRAM writes and raster readback
// a data write is pushed to the queue in the same cycle, the address
// steps by the increment on the next clock whether or not it was queued
// readback data appears one cycle after read_en
//==========================================================================

`timescale 1ns/1ps

module host_registers (
    input  logic clk,
    input  logic reset,

    input  vdp_regs_pkg::host_req_t host_req,

    input  video_timing_pkg::raster_x_t raster_x,
    input  video_timing_pkg::raster_y_t raster_y,

    output logic [15:0] read_data,

    output vdp_regs_pkg::vram_write_t vram_write,
    output logic vram_write_push
);

    // byte-granular VRAM address, bit 0 picks the bank
    logic [14:0] vram_addr;
    logic [7:0] vram_inc;

    always_ff @(posedge clk) begin
        if (reset) begin
            vram_addr <= '0;
            vram_inc <= '0;
        end else if (host_req.write_en) begin
            case (host_req.address)
                vdp_regs_pkg::reg_vram_addr: begin
                    vram_addr <= host_req.write_data[14:0];
                end
                vdp_regs_pkg::reg_vram_data: begin
                    vram_addr <= vram_addr + {7'b0, vram_inc};
                end
                vdp_regs_pkg::reg_vram_inc: begin
                    vram_inc <= host_req.write_data[7:0];
                end
                default: begin
                end
            endcase
        end
    end

    assign vram_write_push = host_req.write_en &&
        host_req.address == vdp_regs_pkg::reg_vram_data;

    // entry uses the address before this write's increment
    assign vram_write = '{
        word_addr: vram_addr[14:1],
        data: host_req.write_data,
        odd_bank: vram_addr[0]
    };

    always_ff @(posedge clk) begin
        if (host_req.read_en) begin
            case (host_req.address)
                vdp_regs_pkg::reg_read_x: read_data <= {4'b0, raster_x};
                vdp_regs_pkg::reg_read_y: read_data <= {5'b0, raster_y};
                default: read_data <= '0;
            endcase
        end
    end

endmodule

// File: source/vram_write_queue.sv
//==========================================================================
// in-order queue of host VRAM writes, vram_queue_depth entries
// a push into a full queue is dropped, the host is expected to track credits
// each granted entry reaches its bank port one clock later with a credit
//==========================================================================

`timescale 1ns/1ps

module vram_write_queue (
    input  logic clk,
    input  logic reset,

    input  vdp_regs_pkg::vram_write_t vram_write,
    input  logic vram_write_push,
    input  logic slot_grant,

    output logic queue_valid,
    output vdp_regs_pkg::vram_port_t vram_even,
    output vdp_regs_pkg::vram_port_t vram_odd,
    output logic vram_credit
);

    typedef logic [$clog2(vdp_regs_pkg::vram_queue_depth + 1) - 1:0] count_t;
    typedef logic [$clog2(vdp_regs_pkg::vram_queue_depth) - 1:0] ptr_t;

    vdp_regs_pkg::vram_write_t entries [vdp_regs_pkg::vram_queue_depth];
    vdp_regs_pkg::vram_write_t head;

    count_t count;
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    logic accept;
    logic pop;

    // registered port state
    logic even_we, odd_we;
    vdp_regs_pkg::vram_word_addr_t even_addr, odd_addr;
    logic [15:0] port_data;

    assign queue_valid = count != '0;
    assign head = entries[rd_ptr];
    assign pop = slot_grant && queue_valid;

    // full is judged before this cycle's pop, its credit has not returned yet
    assign accept = vram_write_push && count != count_t'(vdp_regs_pkg::vram_queue_depth);

    always_ff @(posedge clk) begin
        if (accept) begin
            entries[wr_ptr] <= vram_write;
        end
        port_data <= head.data;
    end

    // pointers wrap naturally while the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (accept) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({accept, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            even_we <= 1'b0;
            odd_we <= 1'b0;
            even_addr <= '0;
            odd_addr <= '0;
            vram_credit <= 1'b0;
        end else begin
            even_we <= pop && !head.odd_bank;
            odd_we <= pop && head.odd_bank;
            even_addr <= (pop && !head.odd_bank) ? head.word_addr : '0;
            odd_addr <= (pop && head.odd_bank) ? head.word_addr : '0;
            vram_credit <= pop;
        end
    end

    // both banks see the same data, only the write enable differs
    assign vram_even = '{address: even_addr, write_en: even_we, write_data: port_data};
    assign vram_odd = '{address: odd_addr, write_en: odd_we, write_data: port_data};

endmodule

// File: source/vdp_top.sv
//==========================================================================
// display processor core: raster timing, host registers and VRAM writes
// host VRAM writes are credit based, vram_credit returns one per write
// no rendering, the VRAM ports only ever carry host writes
//==========================================================================

`timescale 1ns/1ps

module vdp_top (
    input  logic clk,
    input  logic reset,

    // host side
    input  vdp_regs_pkg::host_req_t host_req,
    output logic [15:0] host_read_data,
    output logic vram_credit,

    // video timing
    output logic hsync,
    output logic vsync,
    output logic active_display,
    output logic line_ended,
    output logic frame_ended,

    // VRAM banks
    output vdp_regs_pkg::vram_port_t vram_even,
    output vdp_regs_pkg::vram_port_t vram_odd
);

    video_timing_pkg::raster_x_t raster_x;
    video_timing_pkg::raster_y_t raster_y;

    vdp_regs_pkg::vram_write_t vram_write;
    logic vram_write_push;
    logic queue_valid;
    logic slot_grant;

    raster_timing u_raster_timing (
        .clk            (clk),
        .reset          (reset),
        .raster_x       (raster_x),
        .raster_y       (raster_y),
        .hsync          (hsync),
        .vsync          (vsync),
        .active_display (active_display),
        .line_ended     (line_ended),
        .frame_ended    (frame_ended)
    );

    vram_slot_sequencer u_slot_sequencer (
        .clk         (clk),
        .reset       (reset),
        .raster_y    (raster_y),
        .queue_valid (queue_valid),
        .slot_grant  (slot_grant)
    );

    host_registers u_host_registers (
        .clk             (clk),
        .reset           (reset),
        .host_req        (host_req),
        .raster_x        (raster_x),
        .raster_y        (raster_y),
        .read_data       (host_read_data),
        .vram_write      (vram_write),
        .vram_write_push (vram_write_push)
    );

    vram_write_queue u_write_queue (
        .clk             (clk),
        .reset           (reset),
        .vram_write      (vram_write),
        .vram_write_push (vram_write_push),
        .slot_grant      (slot_grant),
        .queue_valid     (queue_valid),
        .vram_even       (vram_even),
        .vram_odd        (vram_odd),
        .vram_credit     (vram_credit)
    );

endmodule

// File: dv/vdp_tb.sv
//==========================================================================
// self-checking testbench for vdp_top, run from the project root
// host operations and expected VRAM writes come from dv/vdp_stimulus.mem
// runs a little over two frames, about 840k cycles
//==========================================================================

`timescale 1ns/1ps

module vdp_tb;

    localparam int line_cycles = 800;
    localparam int frame_lines = 524;
    localparam int frame_cycles = line_cycles * frame_lines;
    // two full frames are needed for the frame period check
    localparam int timeout_cycles = 2 * frame_cycles + 1000;
    localparam int stim_lines = 32;
    localparam int stim_fields = 5;

    localparam int t_line = 0;
    localparam int t_frame = 1;
    localparam int t_read = 2;
    localparam int t_write = 3;
    localparam int t_burst = 4;

    typedef struct packed {
        logic burst;
        logic odd_bank;
        vdp_regs_pkg::vram_word_addr_t word_addr;
        logic [15:0] data;
    } expect_t;

    logic clk;
    logic reset;
    vdp_regs_pkg::host_req_t host_req;
    logic [15:0] host_read_data;
    logic vram_credit;
    logic hsync;
    logic vsync;
    logic active_display;
    logic line_ended;
    logic frame_ended;
    vdp_regs_pkg::vram_port_t vram_even;
    vdp_regs_pkg::vram_port_t vram_odd;

    logic [15:0] stim [stim_lines * stim_fields];
    expect_t expect_q [$];
    string test_names [5] = '{"line_timing", "frame_timing", "raster_readback",
        "bank_routing", "blank_burst"};
    int test_errors [5];
    int tests_run;
    int tests_failed;

    // host side model of the address register and credits
    logic [14:0] addr_model;
    logic [7:0] inc_model;
    int issued;
    int returned;

    int cycle;
    int last_line_cycle;
    int last_frame_cycle;
    int lines_seen;
    int frames_seen;
    int hsync_low;
    int vsync_low;
    int active_count;
    int line_y;
    int port_writes;
    int credits_seen;
    int last_write_cycle;
    logic last_burst;

    vdp_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input int test, input string what, input int expected,
            input int actual);
        assert (expected == actual) else begin
            $display("** Error %s, %s: expected %0d, actual %0d", test_names[test], what,
                expected, actual);
            test_errors[test]++;
        end
    endtask

    task automatic note_failure(input int test, input string what);
        $display("Error in %s: %s", test_names[test], what);
        test_errors[test]++;
    endtask

    task automatic finish_test(input int test);
        tests_run++;
        if (test_errors[test] == 0) begin
            $display("test %s done, no errors", test_names[test]);
        end else begin
            tests_failed++;
            $display("test %s done, %0d errors", test_names[test], test_errors[test]);
        end
    endtask

    // inputs change 2 ns after the edge, credits are counted there too
    task automatic step();
        @(posedge clk);
        #2;
        if (vram_credit) returned++;
    endtask

    task automatic write_reg(input vdp_regs_pkg::reg_addr_t addr, input logic [15:0] data);
        host_req = '{address: addr, write_data: data, write_en: 1'b1, read_en: 1'b0};
        step();
        host_req = '0;
    endtask

    task automatic read_reg(input vdp_regs_pkg::reg_addr_t addr, output logic [15:0] data);
        host_req = '{address: addr, write_data: 16'h0, write_en: 1'b0, read_en: 1'b1};
        step();
        host_req = '0;
        data = host_read_data;
    endtask

    task automatic wait_line_end();
        do step(); while (!line_ended);
    endtask

    task automatic drain();
        while (issued != returned) step();
    endtask

    task automatic check_timing();
        if (!hsync) hsync_low++;
        if (!vsync) vsync_low++;
        if (active_display) active_count++;
        if (line_ended) begin
            if (lines_seen > 0) begin
                check_value(t_line, "line period", line_cycles, cycle - last_line_cycle);
            end
            check_value(t_line, "hsync low cycles", 96, hsync_low);
            // visible lines carry 640 active pixels, blanking lines none
            check_value(t_line, "active cycles", (line_y < 480) ? 640 : 0, active_count);
            hsync_low = 0;
            active_count = 0;
            last_line_cycle = cycle;
            lines_seen++;
            line_y = (line_y == frame_lines - 1) ? 0 : line_y + 1;
            if (lines_seen == frame_lines) finish_test(t_line);
        end
        if (frame_ended) begin
            if (frames_seen > 0) begin
                check_value(t_frame, "frame period", frame_cycles, cycle - last_frame_cycle);
            end
            // two sync lines per frame
            check_value(t_frame, "vsync low cycles", 2 * line_cycles, vsync_low);
            vsync_low = 0;
            last_frame_cycle = cycle;
            frames_seen++;
            if (frames_seen == 2) finish_test(t_frame);
        end
    endtask

    task automatic check_ports();
        expect_t entry;
        vdp_regs_pkg::vram_port_t port;
        int test;
        if (!vram_even.write_en) begin
            check_value(t_write, "idle even address", 0, int'(vram_even.address));
        end
        if (!vram_odd.write_en) begin
            check_value(t_write, "idle odd address", 0, int'(vram_odd.address));
        end
        if (vram_credit) credits_seen++;
        assert (!vram_credit || vram_even.write_en || vram_odd.write_en) else
            note_failure(t_write, "credit pulse without a bank write");
        if (vram_even.write_en || vram_odd.write_en) begin
            port_writes++;
            assert (!(vram_even.write_en && vram_odd.write_en)) else
                note_failure(t_write, "both bank ports wrote in one cycle");
            assert (expect_q.size() != 0) else
                note_failure(t_write, "bank write with no host write outstanding");
            if (expect_q.size() != 0) begin
                entry = expect_q.pop_front();
                test = entry.burst ? t_burst : t_write;
                port = vram_odd.write_en ? vram_odd : vram_even;
                check_value(test, "odd bank", int'(entry.odd_bank), int'(vram_odd.write_en));
                check_value(test, "word address", int'(entry.word_addr), int'(port.address));
                check_value(test, "data", int'(entry.data), int'(port.write_data));
                check_value(test, "credit with write", 1, int'(vram_credit));
                if (port_writes > 1 && entry.burst && last_burst) begin
                    check_value(test, "cycles between writes", 1, cycle - last_write_cycle);
                end else if (port_writes > 1 && !entry.burst && !last_burst) begin
                    assert (cycle - last_write_cycle >= 8) else
                        note_failure(test, $sformatf("active writes only %0d cycles apart",
                            cycle - last_write_cycle));
                end
                last_write_cycle = cycle;
                last_burst = entry.burst;
            end
        end
    endtask

    // monitor samples at the falling edge, away from input changes
    always @(negedge clk) begin
        if (!reset) begin
            cycle++;
            if (cycle >= timeout_cycles) begin
                $display("run stopped at cycle %0d, the tests did not finish in time", cycle);
                $display("Testbench failed");
                $finish;
            end else begin
                check_timing();
                check_ports();
            end
        end
    end

    initial begin
        logic [15:0] data;
        logic [15:0] op;
        logic [15:0] value;
        expect_t entry;
        int base;
        int line_idx;
        int total_errors;
        logic burst_started;

        host_req = '0;
        reset = 1'b1;
        addr_model = '0;
        inc_model = '0;
        burst_started = 1'b0;
        foreach (stim[i]) stim[i] = '0;
        $readmemh("dv/vdp_stimulus.mem", stim);
        repeat (16) step();
        reset = 1'b0;

        // raster readback right after a line end, y steps by one per line
        repeat (4) begin
            wait_line_end();
            step();
            read_reg(vdp_regs_pkg::reg_read_y, data);
            check_value(t_read, "raster_y", line_y, int'(data));
        end
        wait_line_end();
        step();
        read_reg(vdp_regs_pkg::reg_read_x, data);
        check_value(t_read, "raster_x", 0, int'(data));
        finish_test(t_read);

        line_idx = 0;
        while (line_idx < stim_lines && stim[line_idx * stim_fields] != 16'h0) begin
            base = line_idx * stim_fields;
            op = stim[base];
            value = stim[base + 1];
            case (op)
                16'h1: begin
                    write_reg(vdp_regs_pkg::reg_vram_addr, value);
                    addr_model = value[14:0];
                end
                16'h2: begin
                    write_reg(vdp_regs_pkg::reg_vram_inc, value);
                    inc_model = value[7:0];
                end
                16'h3, 16'h4: begin
                    if (op == 16'h4 && !burst_started) begin
                        drain();
                        finish_test(t_write);
                        while (line_y < 480) step();
                        burst_started = 1'b1;
                    end
                    // at most two writes in flight
                    while (issued - returned >= 2) step();
                    entry = '{burst: op == 16'h4, odd_bank: stim[base + 2][0],
                        word_addr: stim[base + 3][13:0], data: stim[base + 4]};
                    check_value(t_write, "stimulus bank", int'(addr_model[0]),
                        int'(entry.odd_bank));
                    check_value(t_write, "stimulus word address", int'(addr_model[14:1]),
                        int'(entry.word_addr));
                    expect_q.push_back(entry);
                    write_reg(vdp_regs_pkg::reg_vram_data, value);
                    issued++;
                    addr_model = addr_model + {7'b0, inc_model};
                end
                default: note_failure(t_write, "unknown operation code in stimulus file");
            endcase
            line_idx++;
        end

        drain();
        step();
        check_value(t_burst, "bank writes seen", issued, port_writes);
        check_value(t_burst, "credit pulses seen", issued, credits_seen);
        check_value(t_burst, "writes still expected", 0, expect_q.size());
        finish_test(t_burst);

        while (frames_seen < 2) step();
        total_errors = 0;
        foreach (test_errors[i]) total_errors += test_errors[i];
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
            total_errors);
        if (tests_failed == 0 && total_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: dv/vdp_stimulus.mem
// op value bank word data, op 1 set address, 2 set increment, 3 write, 4 vblank write
// bank, word and data are the expected VRAM write, zero for register ops
1 0010 0 0000 0000
2 0002 0 0000 0000
3 a5a5 0 0008 a5a5
3 5a5a 0 0009 5a5a
1 0101 0 0000 0000
2 0003 0 0000 0000
3 1234 1 0080 1234
3 beef 0 0082 beef
3 cafe 1 0083 cafe
3 0f0f 0 0085 0f0f
1 7ffe 0 0000 0000
2 0001 0 0000 0000
3 1111 0 3fff 1111
3 2222 1 3fff 2222
1 2000 0 0000 0000
2 0005 0 0000 0000
4 0001 0 1000 0001
4 0002 1 1002 0002
4 0003 0 1005 0003
4 0004 1 1007 0004
4 0005 0 100a 0005
4 0006 1 100c 0006

// File: all.f
source/video_timing_pkg.sv
source/vdp_regs_pkg.sv
source/raster_timing.sv
source/vram_slot_sequencer.sv
source/host_registers.sv
source/vram_write_queue.sv
source/vdp_top.sv
dv/vdp_tb.sv

// File: Makefile
TOP := vdp_tb
BUILD := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module vdp_top

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee sim.log
	@if grep -q "Testbench failed" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf $(BUILD) sim.log
